// File: design/lmem_pkg.sv
// Local memory package with bank geometry and the memory opcode
package lmem_pkg;

    // Requester and bank counts
    localparam int NUM_REQS      = 4;
    localparam int NUM_BANKS     = 4;
    localparam int REQ_SEL_WIDTH = 2;

    // Low word-address bits pick the bank
    localparam int BANK_SEL_BITS = 2;

    // Word shape
    localparam int WORD_BYTES = 4;
    localparam int WORD_WIDTH = 32;

    // Rows per bank
    localparam int WORDS_PER_BANK  = 64;
    localparam int BANK_ADDR_WIDTH = 6;

    // Full word address, row above bank select
    localparam int ADDR_WIDTH = BANK_ADDR_WIDTH + BANK_SEL_BITS;

    // Opaque tag handed back with read data
    localparam int TAG_WIDTH = 8;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

endpackage

// File: design/rr_arbiter.sv
// Round-robin arbiter that grants one requester and rotates on each accepted grant
`timescale 1ns/10ps

module rr_arbiter #(
    parameter int NUM = 4
) (
    input  logic           clk,
    input  logic           reset,
    input  logic [NUM-1:0] request,
    input  logic           accept,
    output logic [NUM-1:0] grant
);

    // Set bits mark requesters at or after the priority pointer
    logic [NUM-1:0] mask;
    logic [NUM-1:0] masked_req;
    logic [NUM-1:0] pick;
    logic [NUM-1:0] grant_q;
    logic           hold;

    assign masked_req = request & mask;

    // Lowest set bit above the pointer, else wrap to the lowest overall
    always_comb begin
        if (|masked_req) begin
            pick = masked_req & (~masked_req + NUM'(1));
        end else begin
            pick = request & (~request + NUM'(1));
        end
    end

    // A presented grant stays put until taken, so the winner's payload holds
    assign grant = (hold && |(grant_q & request)) ? grant_q : pick;

    always_ff @(posedge clk) begin
        if (reset) begin
            mask <= '1;
            hold <= 1'b0;
        end else begin
            hold <= |grant && !accept;
            if (accept && |grant) begin
                // Pointer goes one past the winner
                mask <= ~(grant | (grant - NUM'(1)));
            end
        end
    end

    always_ff @(posedge clk) begin
        grant_q <= grant;
    end

endmodule

// File: design/bank_dispatch.sv
// Bank dispatch that decodes request addresses and arbitrates requesters per bank
`timescale 1ns/10ps

module bank_dispatch (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic [lmem_pkg::NUM_REQS-1:0]                           req_valid,
    input  lmem_pkg::mem_op_e [lmem_pkg::NUM_REQS-1:0]              req_op,
    input  logic [lmem_pkg::NUM_REQS-1:0][lmem_pkg::ADDR_WIDTH-1:0] req_addr,
    input  logic [lmem_pkg::NUM_REQS-1:0][lmem_pkg::WORD_BYTES-1:0] req_byteen,
    input  logic [lmem_pkg::NUM_REQS-1:0][lmem_pkg::WORD_WIDTH-1:0] req_wdata,
    input  logic [lmem_pkg::NUM_REQS-1:0][lmem_pkg::TAG_WIDTH-1:0]  req_tag,
    output logic [lmem_pkg::NUM_REQS-1:0]                           req_ready,
    output logic [lmem_pkg::NUM_BANKS-1:0]                          bank_req_valid,
    output lmem_pkg::mem_op_e [lmem_pkg::NUM_BANKS-1:0]             bank_req_op,
    output logic [lmem_pkg::NUM_BANKS-1:0][lmem_pkg::BANK_ADDR_WIDTH-1:0] bank_req_row,
    output logic [lmem_pkg::NUM_BANKS-1:0][lmem_pkg::WORD_BYTES-1:0] bank_req_byteen,
    output logic [lmem_pkg::NUM_BANKS-1:0][lmem_pkg::WORD_WIDTH-1:0] bank_req_wdata,
    output logic [lmem_pkg::NUM_BANKS-1:0][lmem_pkg::TAG_WIDTH-1:0]  bank_req_tag,
    output logic [lmem_pkg::NUM_BANKS-1:0][lmem_pkg::REQ_SEL_WIDTH-1:0] bank_req_idx,
    input  logic [lmem_pkg::NUM_BANKS-1:0]                          bank_req_ready
);
    import lmem_pkg::*;

    logic [NUM_BANKS-1:0][NUM_REQS-1:0] bank_hit;
    logic [NUM_BANKS-1:0][NUM_REQS-1:0] bank_grant;

    // Which bank each valid request targets
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int r = 0; r < NUM_REQS; r++) begin
                bank_hit[b][r] = req_valid[r]
                    && (req_addr[r][BANK_SEL_BITS-1:0] == BANK_SEL_BITS'(b));
            end
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank_arb
        rr_arbiter #(
            .NUM (NUM_REQS)
        ) u_arb (
            .clk     (clk),
            .reset   (reset),
            .request (bank_hit[b]),
            .accept  (bank_req_valid[b] && bank_req_ready[b]),
            .grant   (bank_grant[b])
        );
    end

    // Winner's fields onto each bank port
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_req_valid[b]  = |bank_grant[b];
            bank_req_op[b]     = OP_READ;
            bank_req_row[b]    = '0;
            bank_req_byteen[b] = '0;
            bank_req_wdata[b]  = '0;
            bank_req_tag[b]    = '0;
            bank_req_idx[b]    = '0;
            for (int r = 0; r < NUM_REQS; r++) begin
                if (bank_grant[b][r]) begin
                    bank_req_op[b]     = req_op[r];
                    bank_req_row[b]    = req_addr[r][ADDR_WIDTH-1:BANK_SEL_BITS];
                    bank_req_byteen[b] = req_byteen[r];
                    bank_req_wdata[b]  = req_wdata[r];
                    bank_req_tag[b]    = req_tag[r];
                    bank_req_idx[b]    = REQ_SEL_WIDTH'(r);
                end
            end
        end
    end

    // Accepted only when the bank also takes it
    always_comb begin
        for (int r = 0; r < NUM_REQS; r++) begin
            req_ready[r] = 1'b0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                req_ready[r] = req_ready[r] | (bank_grant[b][r] & bank_req_ready[b]);
            end
        end
    end

endmodule

// File: design/lmem_bank.sv
// Single-port byte-enabled RAM bank with a one-entry read response register
`timescale 1ns/10ps

module lmem_bank (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 bank_req_valid,
    input  lmem_pkg::mem_op_e                    bank_req_op,
    input  logic [lmem_pkg::BANK_ADDR_WIDTH-1:0] bank_req_row,
    input  logic [lmem_pkg::WORD_BYTES-1:0]      bank_req_byteen,
    input  logic [lmem_pkg::WORD_WIDTH-1:0]      bank_req_wdata,
    input  logic [lmem_pkg::TAG_WIDTH-1:0]       bank_req_tag,
    input  logic [lmem_pkg::REQ_SEL_WIDTH-1:0]   bank_req_idx,
    output logic                                 bank_req_ready,
    output logic                                 bank_rsp_valid,
    output logic [lmem_pkg::WORD_WIDTH-1:0]      bank_rsp_data,
    output logic [lmem_pkg::TAG_WIDTH-1:0]       bank_rsp_tag,
    output logic [lmem_pkg::REQ_SEL_WIDTH-1:0]   bank_rsp_idx,
    input  logic                                 bank_rsp_ready
);
    import lmem_pkg::*;

    logic [WORD_WIDTH-1:0] mem [WORDS_PER_BANK];

    logic req_fire;
    logic wr_fire;
    logic rd_fire;
    logic rsp_fire;

    assign rsp_fire = bank_rsp_valid && bank_rsp_ready;

    // Writes never wait; reads need the response slot free or draining
    assign bank_req_ready = (bank_req_op == OP_WRITE) || !bank_rsp_valid || bank_rsp_ready;

    assign req_fire = bank_req_valid && bank_req_ready;
    assign wr_fire  = req_fire && (bank_req_op == OP_WRITE);
    assign rd_fire  = req_fire && (bank_req_op == OP_READ);

    // Byte lanes written only where enabled
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                if (bank_req_byteen[i]) begin
                    mem[bank_req_row][i*8 +: 8] <= bank_req_wdata[i*8 +: 8];
                end
            end
        end
    end

    // Response slot fills on a read, empties when drained
    always_ff @(posedge clk) begin
        if (reset) begin
            bank_rsp_valid <= 1'b0;
        end else if (rd_fire) begin
            bank_rsp_valid <= 1'b1;
        end else if (rsp_fire) begin
            bank_rsp_valid <= 1'b0;
        end
    end

    // Payload only moves on a new read, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            bank_rsp_data <= mem[bank_req_row];
            bank_rsp_tag  <= bank_req_tag;
            bank_rsp_idx  <= bank_req_idx;
        end
    end

endmodule

// File: design/rsp_router.sv
// Response router that returns bank read data to the requester that asked
`timescale 1ns/10ps

module rsp_router (
    input  logic                                                         clk,
    input  logic                                                         reset,
    input  logic [lmem_pkg::NUM_BANKS-1:0]                               bank_rsp_valid,
    input  logic [lmem_pkg::NUM_BANKS-1:0][lmem_pkg::WORD_WIDTH-1:0]     bank_rsp_data,
    input  logic [lmem_pkg::NUM_BANKS-1:0][lmem_pkg::TAG_WIDTH-1:0]      bank_rsp_tag,
    input  logic [lmem_pkg::NUM_BANKS-1:0][lmem_pkg::REQ_SEL_WIDTH-1:0]  bank_rsp_idx,
    output logic [lmem_pkg::NUM_BANKS-1:0]                               bank_rsp_ready,
    output logic [lmem_pkg::NUM_REQS-1:0]                                rsp_valid,
    output logic [lmem_pkg::NUM_REQS-1:0][lmem_pkg::WORD_WIDTH-1:0]      rsp_data,
    output logic [lmem_pkg::NUM_REQS-1:0][lmem_pkg::TAG_WIDTH-1:0]       rsp_tag,
    input  logic [lmem_pkg::NUM_REQS-1:0]                                rsp_ready
);
    import lmem_pkg::*;

    logic [NUM_REQS-1:0][NUM_BANKS-1:0] req_hit;
    logic [NUM_REQS-1:0][NUM_BANKS-1:0] req_grant;

    // Banks holding a response for each requester
    always_comb begin
        for (int r = 0; r < NUM_REQS; r++) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                req_hit[r][b] = bank_rsp_valid[b]
                    && (bank_rsp_idx[b] == REQ_SEL_WIDTH'(r));
            end
        end
    end

    for (genvar r = 0; r < NUM_REQS; r++) begin : g_req_arb
        rr_arbiter #(
            .NUM (NUM_BANKS)
        ) u_arb (
            .clk     (clk),
            .reset   (reset),
            .request (req_hit[r]),
            .accept  (rsp_valid[r] && rsp_ready[r]),
            .grant   (req_grant[r])
        );
    end

    // Winning bank's word and tag to the requester
    always_comb begin
        for (int r = 0; r < NUM_REQS; r++) begin
            rsp_valid[r] = |req_hit[r];
            rsp_data[r]  = '0;
            rsp_tag[r]   = '0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (req_grant[r][b]) begin
                    rsp_data[r] = bank_rsp_data[b];
                    rsp_tag[r]  = bank_rsp_tag[b];
                end
            end
        end
    end

    // A bank drains only when its requester takes the word
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_rsp_ready[b] = 1'b0;
            for (int r = 0; r < NUM_REQS; r++) begin
                bank_rsp_ready[b] = bank_rsp_ready[b] | (req_grant[r][b] & rsp_ready[r]);
            end
        end
    end

endmodule

// File: design/local_mem.sv
// Banked local memory shared by several requesters with tagged read responses
`timescale 1ns/10ps

module local_mem (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic [lmem_pkg::NUM_REQS-1:0]                           req_valid,
    input  lmem_pkg::mem_op_e [lmem_pkg::NUM_REQS-1:0]              req_op,
    input  logic [lmem_pkg::NUM_REQS-1:0][lmem_pkg::ADDR_WIDTH-1:0] req_addr,
    input  logic [lmem_pkg::NUM_REQS-1:0][lmem_pkg::WORD_BYTES-1:0] req_byteen,
    input  logic [lmem_pkg::NUM_REQS-1:0][lmem_pkg::WORD_WIDTH-1:0] req_wdata,
    input  logic [lmem_pkg::NUM_REQS-1:0][lmem_pkg::TAG_WIDTH-1:0]  req_tag,
    output logic [lmem_pkg::NUM_REQS-1:0]                           req_ready,
    output logic [lmem_pkg::NUM_REQS-1:0]                           rsp_valid,
    output logic [lmem_pkg::NUM_REQS-1:0][lmem_pkg::WORD_WIDTH-1:0] rsp_data,
    output logic [lmem_pkg::NUM_REQS-1:0][lmem_pkg::TAG_WIDTH-1:0]  rsp_tag,
    input  logic [lmem_pkg::NUM_REQS-1:0]                           rsp_ready
);
    import lmem_pkg::*;

    // Dispatch to bank
    logic [NUM_BANKS-1:0]                      bank_req_valid;
    mem_op_e [NUM_BANKS-1:0]                   bank_req_op;
    logic [NUM_BANKS-1:0][BANK_ADDR_WIDTH-1:0] bank_req_row;
    logic [NUM_BANKS-1:0][WORD_BYTES-1:0]      bank_req_byteen;
    logic [NUM_BANKS-1:0][WORD_WIDTH-1:0]      bank_req_wdata;
    logic [NUM_BANKS-1:0][TAG_WIDTH-1:0]       bank_req_tag;
    logic [NUM_BANKS-1:0][REQ_SEL_WIDTH-1:0]   bank_req_idx;
    logic [NUM_BANKS-1:0]                      bank_req_ready;

    // Bank to router
    logic [NUM_BANKS-1:0]                      bank_rsp_valid;
    logic [NUM_BANKS-1:0][WORD_WIDTH-1:0]      bank_rsp_data;
    logic [NUM_BANKS-1:0][TAG_WIDTH-1:0]       bank_rsp_tag;
    logic [NUM_BANKS-1:0][REQ_SEL_WIDTH-1:0]   bank_rsp_idx;
    logic [NUM_BANKS-1:0]                      bank_rsp_ready;

    bank_dispatch u_dispatch (
        .clk             (clk),
        .reset           (reset),
        .req_valid       (req_valid),
        .req_op          (req_op),
        .req_addr        (req_addr),
        .req_byteen      (req_byteen),
        .req_wdata       (req_wdata),
        .req_tag         (req_tag),
        .req_ready       (req_ready),
        .bank_req_valid  (bank_req_valid),
        .bank_req_op     (bank_req_op),
        .bank_req_row    (bank_req_row),
        .bank_req_byteen (bank_req_byteen),
        .bank_req_wdata  (bank_req_wdata),
        .bank_req_tag    (bank_req_tag),
        .bank_req_idx    (bank_req_idx),
        .bank_req_ready  (bank_req_ready)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        lmem_bank u_bank (
            .clk             (clk),
            .reset           (reset),
            .bank_req_valid  (bank_req_valid[b]),
            .bank_req_op     (bank_req_op[b]),
            .bank_req_row    (bank_req_row[b]),
            .bank_req_byteen (bank_req_byteen[b]),
            .bank_req_wdata  (bank_req_wdata[b]),
            .bank_req_tag    (bank_req_tag[b]),
            .bank_req_idx    (bank_req_idx[b]),
            .bank_req_ready  (bank_req_ready[b]),
            .bank_rsp_valid  (bank_rsp_valid[b]),
            .bank_rsp_data   (bank_rsp_data[b]),
            .bank_rsp_tag    (bank_rsp_tag[b]),
            .bank_rsp_idx    (bank_rsp_idx[b]),
            .bank_rsp_ready  (bank_rsp_ready[b])
        );
    end

    rsp_router u_router (
        .clk            (clk),
        .reset          (reset),
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp_data  (bank_rsp_data),
        .bank_rsp_tag   (bank_rsp_tag),
        .bank_rsp_idx   (bank_rsp_idx),
        .bank_rsp_ready (bank_rsp_ready),
        .rsp_valid      (rsp_valid),
        .rsp_data       (rsp_data),
        .rsp_tag        (rsp_tag),
        .rsp_ready      (rsp_ready)
    );

endmodule

// File: verification/local_mem_props.sv
// Bound checks on response hold, per-bank acceptance and response valid after reset
`timescale 1ns/10ps

module local_mem_props #(
    parameter int BANKS = 1,
    parameter int REQS  = 1
) (
    input logic                                       clk,
    input logic                                       reset,
    input logic [BANKS-1:0]                           bank_rsp_valid,
    input logic [BANKS-1:0]                           bank_rsp_ready,
    input logic [BANKS-1:0][lmem_pkg::WORD_WIDTH-1:0] bank_rsp_data,
    input logic [BANKS-1:0][lmem_pkg::TAG_WIDTH-1:0]  bank_rsp_tag,
    input logic [REQS-1:0]                            req_valid,
    input logic [REQS-1:0]                            req_ready,
    input logic [REQS-1:0][lmem_pkg::ADDR_WIDTH-1:0]  req_addr,
    input logic [REQS-1:0]                            rsp_valid
);
    import lmem_pkg::*;

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
            bank_rsp_valid[b] && !bank_rsp_ready[b] |=>
                bank_rsp_valid[b] && $stable(bank_rsp_data[b]) && $stable(bank_rsp_tag[b]))
            else $error("Bank %0d response changed while stalled", b);
    end

    // Two requests only meet in a bank where several requesters share it
    if (REQS > 1) begin : g_grant
        logic [BANKS-1:0][REQS-1:0] taken;

        // Requests accepted into each bank this cycle
        always_comb begin
            for (int b = 0; b < BANKS; b++) begin
                for (int r = 0; r < REQS; r++) begin
                    taken[b][r] = req_valid[r] && req_ready[r]
                        && (int'(req_addr[r][BANK_SEL_BITS-1:0]) == b);
                end
            end
        end

        for (genvar b = 0; b < BANKS; b++) begin : g_bank
            a_one_grant: assert property (@(posedge clk) disable iff (reset)
                $onehot0(taken[b]))
                else $error("Bank %0d accepted more than one request in a cycle", b);
        end
    end

    a_rsp_idle: assert property (@(posedge clk) $fell(reset) |-> rsp_valid == '0)
        else $error("Response valid high in the first cycle after reset");

endmodule

// File: verification/local_mem_tb.sv
// Testbench for the banked local memory with a reference memory and tag scoreboard
`timescale 1ns/10ps

module local_mem_tb;
    import lmem_pkg::*;

    localparam int NUM_ROWS = 8;
    // Rows with random response back-pressure
    localparam logic [NUM_ROWS-1:0] ROW_BP  = 8'b1110_0000;
    // Rows whose lanes must all be accepted in the first cycle
    localparam logic [NUM_ROWS-1:0] ROW_ONE = 8'b0000_1001;

    typedef struct packed {
        logic                  valid;
        mem_op_e               op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [WORD_BYTES-1:0] byteen;
        logic [WORD_WIDTH-1:0] wdata;
        logic [TAG_WIDTH-1:0]  tag;
    } lane_t;

    logic                                  clk;
    logic                                  reset;
    logic [NUM_REQS-1:0]                   req_valid;
    mem_op_e [NUM_REQS-1:0]                req_op;
    logic [NUM_REQS-1:0][ADDR_WIDTH-1:0]   req_addr;
    logic [NUM_REQS-1:0][WORD_BYTES-1:0]   req_byteen;
    logic [NUM_REQS-1:0][WORD_WIDTH-1:0]   req_wdata;
    logic [NUM_REQS-1:0][TAG_WIDTH-1:0]    req_tag;
    logic [NUM_REQS-1:0]                   req_ready;
    logic [NUM_REQS-1:0]                   rsp_valid;
    logic [NUM_REQS-1:0][WORD_WIDTH-1:0]   rsp_data;
    logic [NUM_REQS-1:0][TAG_WIDTH-1:0]    rsp_tag;
    logic [NUM_REQS-1:0]                   rsp_ready;

    lane_t                 tbl [NUM_ROWS][NUM_REQS] = '{default: '0};
    logic [WORD_WIDTH-1:0] ref_mem [2**ADDR_WIDTH];
    logic [WORD_WIDTH-1:0] exp_data [NUM_REQS][2**TAG_WIDTH];
    logic                  exp_pend [NUM_REQS][2**TAG_WIDTH] = '{default: 1'b0};
    int                    acc_cycle [NUM_REQS][2**TAG_WIDTH];
    int                    outstanding [NUM_REQS] = '{default: 0};
    int                    data_errors = 0;
    int                    proto_errors = 0;
    logic [NUM_REQS-1:0]   accepted;
    logic [31:0]           lfsr;
    int                    cycle;
    int                    row_start;
    logic                  checking;
    logic                  cur_bp;
    logic                  cur_one;

    local_mem u_local_mem (.*);

    bind lmem_bank local_mem_props #(.BANKS(1), .REQS(1)) u_bank_props (
        .req_valid (bank_req_valid),
        .req_ready (bank_req_ready),
        .req_addr  ({bank_req_row, 2'b00}),
        .rsp_valid (bank_rsp_valid),
        .*
    );
    bind local_mem local_mem_props #(
        .BANKS (lmem_pkg::NUM_BANKS),
        .REQS  (lmem_pkg::NUM_REQS)
    ) u_top_props (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (reset) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int total_outstanding();
        int sum;
        sum = 0;
        for (int r = 0; r < NUM_REQS; r++) begin
            sum += outstanding[r];
        end
        return sum;
    endfunction

    task automatic set_lane(input int row, input int r, input mem_op_e op,
                            input logic [7:0] addr, input logic [3:0] be,
                            input logic [31:0] data, input logic [7:0] tag);
        tbl[row][r] = '{1'b1, op, addr, be, data, tag};
    endtask

    task automatic load_table();
        // One full word per bank
        set_lane(0, 0, OP_WRITE, 8'h00, 4'hf, 32'h1122_3344, 8'h00);
        set_lane(0, 1, OP_WRITE, 8'h01, 4'hf, 32'haabb_ccdd, 8'h00);
        set_lane(0, 2, OP_WRITE, 8'h02, 4'hf, 32'h0102_0304, 8'h00);
        set_lane(0, 3, OP_WRITE, 8'h03, 4'hf, 32'hdead_beef, 8'h00);
        // All four into bank 0
        set_lane(1, 0, OP_WRITE, 8'h04, 4'hf, 32'h4444_0004, 8'h00);
        set_lane(1, 1, OP_WRITE, 8'h08, 4'hf, 32'h8888_0008, 8'h00);
        set_lane(1, 2, OP_WRITE, 8'h0c, 4'hf, 32'hcccc_000c, 8'h00);
        set_lane(1, 3, OP_WRITE, 8'h10, 4'hf, 32'h1010_0010, 8'h00);
        // Partial byte merges
        set_lane(2, 0, OP_WRITE, 8'h00, 4'h5, 32'ha5a5_a5a5, 8'h00);
        set_lane(2, 1, OP_WRITE, 8'h01, 4'h8, 32'h7700_0000, 8'h00);
        set_lane(2, 3, OP_WRITE, 8'h03, 4'h6, 32'h00ca_fe00, 8'h00);
        set_lane(3, 0, OP_READ, 8'h00, 4'h0, 32'h0, 8'h10);
        set_lane(3, 1, OP_READ, 8'h01, 4'h0, 32'h0, 8'h11);
        set_lane(3, 2, OP_READ, 8'h02, 4'h0, 32'h0, 8'h12);
        set_lane(3, 3, OP_READ, 8'h03, 4'h0, 32'h0, 8'h13);
        // Round robin on one bank
        set_lane(4, 0, OP_READ, 8'h04, 4'h0, 32'h0, 8'h20);
        set_lane(4, 1, OP_READ, 8'h08, 4'h0, 32'h0, 8'h21);
        set_lane(4, 2, OP_READ, 8'h0c, 4'h0, 32'h0, 8'h22);
        set_lane(4, 3, OP_READ, 8'h10, 4'h0, 32'h0, 8'h23);
        set_lane(5, 0, OP_READ, 8'h03, 4'h0, 32'h0, 8'h30);
        set_lane(5, 1, OP_READ, 8'h02, 4'h0, 32'h0, 8'h31);
        set_lane(5, 2, OP_READ, 8'h01, 4'h0, 32'h0, 8'h32);
        set_lane(5, 3, OP_READ, 8'h00, 4'h0, 32'h0, 8'h33);
        set_lane(6, 0, OP_READ, 8'h10, 4'h0, 32'h0, 8'h40);
        set_lane(6, 1, OP_READ, 8'h0c, 4'h0, 32'h0, 8'h41);
        set_lane(6, 2, OP_READ, 8'h08, 4'h0, 32'h0, 8'h42);
        set_lane(6, 3, OP_READ, 8'h04, 4'h0, 32'h0, 8'h43);
        set_lane(7, 0, OP_WRITE, 8'h02, 4'hf, 32'h1357_9bdf, 8'h00);
        set_lane(7, 1, OP_READ, 8'h08, 4'h0, 32'h0, 8'h50);
        set_lane(7, 2, OP_READ, 8'h04, 4'h0, 32'h0, 8'h51);
        set_lane(7, 3, OP_READ, 8'h00, 4'h0, 32'h0, 8'h52);
    endtask

    task automatic drive_rsp_ready();
        for (int r = 0; r < NUM_REQS; r++) begin
            if (cur_bp) begin
                lfsr = lfsr_next(lfsr);
                rsp_ready[r] = lfsr[0];
            end else begin
                rsp_ready[r] = 1'b1;
            end
        end
    endtask

    task automatic drain_responses();
        while (total_outstanding() != 0) begin
            @(posedge clk);
            #1;
            drive_rsp_ready();
        end
    endtask

    task automatic apply_row(input int row);
        logic [NUM_REQS-1:0] waiting;
        cur_bp = ROW_BP[row];
        cur_one = ROW_ONE[row];
        row_start = cycle;
        for (int r = 0; r < NUM_REQS; r++) begin
            waiting[r]    = tbl[row][r].valid;
            req_op[r]     = tbl[row][r].op;
            req_addr[r]   = tbl[row][r].addr;
            req_byteen[r] = tbl[row][r].byteen;
            req_wdata[r]  = tbl[row][r].wdata;
            req_tag[r]    = tbl[row][r].tag;
        end
        req_valid = waiting;
        drive_rsp_ready();
        // Hold each lane until it is taken
        while (waiting != '0) begin
            @(posedge clk);
            #1;
            waiting = waiting & ~accepted;
            req_valid = waiting;
            drive_rsp_ready();
        end
        // Back-pressured rows overlap so several banks can answer one requester
        if (!cur_bp) begin
            drain_responses();
        end
    endtask

    task automatic record_request(input int r);
        logic [ADDR_WIDTH-1:0] a;
        a = req_addr[r];
        if (!cur_bp && cycle - row_start >= NUM_REQS) begin
            $display("Requester %0d waited %0d cycles for its bank", r, cycle - row_start);
            proto_errors++;
        end
        if (cur_one && cycle != row_start) begin
            $display("Requester %0d was not accepted in the first cycle of its row", r);
            proto_errors++;
        end
        if (req_op[r] == OP_WRITE) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                if (req_byteen[r][i]) begin
                    ref_mem[a][i*8 +: 8] = req_wdata[r][i*8 +: 8];
                end
            end
        end else begin
            exp_data[r][req_tag[r]]  = ref_mem[a];
            exp_pend[r][req_tag[r]]  = 1'b1;
            acc_cycle[r][req_tag[r]] = cycle;
            outstanding[r]++;
        end
    endtask

    task automatic check_response(input int r);
        logic [TAG_WIDTH-1:0] tag;
        tag = rsp_tag[r];
        if (!exp_pend[r][tag]) begin
            $display("Requester %0d got tag %h that was not pending", r, tag);
            proto_errors++;
        end else begin
            if (rsp_data[r] !== exp_data[r][tag]) begin
                $display("Fail rsp_data[%0d] tag %h: got %h, expected %h",
                         r, tag, rsp_data[r], exp_data[r][tag]);
                data_errors++;
            end
            if (!cur_bp && cycle != acc_cycle[r][tag] + 1) begin
                $display("Requester %0d tag %h came back %0d cycles after its accept, not 1",
                         r, tag, cycle - acc_cycle[r][tag]);
                proto_errors++;
            end
            exp_pend[r][tag] = 1'b0;
            outstanding[r]--;
        end
    endtask

    // Mid-cycle sampling of what fires on the next rising edge
    always @(negedge clk) begin
        if (checking) begin
            accepted = req_valid & req_ready;
            for (int r = 0; r < NUM_REQS; r++) begin
                if (rsp_valid[r] && outstanding[r] == 0) begin
                    $display("Response on requester %0d with no read outstanding", r);
                    proto_errors++;
                end else if (rsp_valid[r] && rsp_ready[r]) begin
                    check_response(r);
                end
                if (accepted[r]) begin
                    record_request(r);
                end
            end
        end else begin
            accepted = '0;
        end
    end

    initial begin
        repeat (NUM_ROWS * 20 + 200) @(posedge clk);
        $display("Timeout: the run did not finish in %0d cycles", NUM_ROWS * 20 + 200);
        $display("Something failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        req_valid = '0;
        for (int r = 0; r < NUM_REQS; r++) begin
            req_op[r] = OP_READ;
        end
        req_addr = '0;
        req_byteen = '0;
        req_wdata = '0;
        req_tag = '0;
        rsp_ready = '0;
        lfsr = 32'hc10e;
        checking = 1'b0;
        cur_bp = 1'b0;
        cur_one = 1'b0;
        row_start = 0;
        load_table();
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        rsp_ready = '1;
        checking = 1'b1;
        for (int row = 0; row < NUM_ROWS; row++) begin
            apply_row(row);
        end
        drain_responses();
        repeat (4) @(posedge clk);
        $display("Errors: %0d data, %0d protocol", data_errors, proto_errors);
        if (data_errors + proto_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: all.f
design/lmem_pkg.sv
design/rr_arbiter.sv
design/bank_dispatch.sv
design/lmem_bank.sv
design/rsp_router.sv
design/local_mem.sv
verification/local_mem_props.sv
verification/local_mem_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the local memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module local_mem_tb -f all.f -o local_mem_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/local_mem_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Everything OK" sim.log; then
    exit 0
fi
exit 1
